// ==== hw/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ================================================
// Memory
`define RAM_ADDR_BITS 8 // Decoded address bits, upper bits ignored

// ================================================
// Control
`define MICROSTEPS 8 // ROM depth per opcode

// Value written to PC by load_origin
`define RESET_VECTOR 16'h0000

`endif

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

    // ================================================
    // Widths with a meaning
    typedef logic [7:0]  data_t;  // Data byte
    typedef logic [15:0] addr_t;  // Full address
    typedef logic [2:0]  flags_t; // {N, C, Z}

    localparam int FLAG_Z = 0; // Zero
    localparam int FLAG_C = 1; // Carry or no-borrow
    localparam int FLAG_N = 2; // Negative

    // ================================================
    // Instruction set
    typedef enum logic [7:0] {
        NOP   = 8'h00,
        HLT   = 8'h01,
        LDA   = 8'h0A, // A <= mem[abs16]
        LDI_A = 8'h0C, // A <= imm8
        ADDI  = 8'h10,
        SUBI  = 8'h11,
        OUT   = 8'h20, // Strobe A out
        JMP   = 8'h30,
        JZ    = 8'h31,
        JC    = 8'h32,
        JN    = 8'h33
    } opcode_t;

    // ================================================
    // Sequencer
    typedef enum logic [2:0] {
        S_RESET, S_INIT, S_LATCH_ADDR, S_READ_BYTE,
        S_LATCH_BYTE, S_CHK_MORE_BYTES, S_EXECUTE, S_HALT
    } fsm_state_t;

    typedef enum logic [2:0] {
        MS0, MS1, MS2, MS3, MS4, MS5, MS6, MS7
    } microstep_t;

    // One bit per datapath action, stored whole in the ROM
    typedef struct packed {
        logic load_origin;
        logic load_mar_pc;
        logic load_mar_addr_low;
        logic load_mar_addr_high;
        logic oe_ram;
        logic oe_temp_1;
        logic oe_temp_2;
        logic pc_enable;
        logic load_pc;
        logic load_ir;
        logic load_temp_1;
        logic load_temp_2;
        logic load_a;
        logic alu_add;
        logic alu_sub;
        logic load_flags;
        logic load_sets_zn;
        logic out_strobe;
        logic check_zero;
        logic check_carry;
        logic check_negative;
        logic last_step;
        logic halt;
    } control_word_t;

endpackage

// ==== hw/control_unit.sv ====
`include "cpu_config.svh"

module control_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_pkg::opcode_t      opcode,
    input  cpu_pkg::flags_t       flags,
    output cpu_pkg::control_word_t control_word,
    output logic                  halted
);

    // ================================================
    // State
    cpu_pkg::fsm_state_t current_state;
    cpu_pkg::fsm_state_t next_state;
    cpu_pkg::microstep_t current_microstep;
    cpu_pkg::microstep_t next_microstep;

    logic [1:0] current_byte_count; // Bytes fetched so far
    logic [1:0] next_byte_count;
    logic [1:0] num_operand_bytes;  // Operands the opcode declares
    logic       opcode_known;

    logic check_jump;     // Step tests a flag
    logic jump_satisfied; // Tested flag is set

    cpu_pkg::control_word_t microcode_rom [256][`MICROSTEPS];

    // ================================================
    // Opcode decode
    always_comb begin
        num_operand_bytes = 2'd0;
        opcode_known = 1'b1;
        case (opcode)
            cpu_pkg::NOP, cpu_pkg::HLT, cpu_pkg::OUT: num_operand_bytes = 2'd0;
            cpu_pkg::LDI_A, cpu_pkg::ADDI, cpu_pkg::SUBI: num_operand_bytes = 2'd1;
            cpu_pkg::LDA, cpu_pkg::JMP, cpu_pkg::JZ,
            cpu_pkg::JC, cpu_pkg::JN: num_operand_bytes = 2'd2; // 16-bit address
            default: opcode_known = 1'b0; // Halts after fetch
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            current_state <= cpu_pkg::S_RESET;
            current_microstep <= cpu_pkg::MS0;
            current_byte_count <= 2'd0;
        end else begin
            current_state <= next_state;
            current_microstep <= next_microstep;
            current_byte_count <= next_byte_count;
        end
    end

    // ================================================
    // Next state and control word
    always_comb begin
        next_state = current_state;
        next_microstep = current_microstep;
        next_byte_count = current_byte_count;
        control_word = '0;
        check_jump = 1'b0;
        jump_satisfied = 1'b0;

        case (current_state)
            cpu_pkg::S_RESET: next_state = cpu_pkg::S_INIT;
            cpu_pkg::S_INIT: begin
                control_word.load_origin = 1'b1; // PC <= reset vector
                next_state = cpu_pkg::S_LATCH_ADDR;
            end
            cpu_pkg::S_LATCH_ADDR: begin
                control_word.load_mar_pc = 1'b1; // MAR <= PC
                next_state = cpu_pkg::S_READ_BYTE;
            end
            cpu_pkg::S_READ_BYTE: begin
                control_word.oe_ram = 1'b1; // Let the bus settle
                next_state = cpu_pkg::S_LATCH_BYTE;
            end
            cpu_pkg::S_LATCH_BYTE: begin
                control_word.oe_ram = 1'b1;
                control_word.pc_enable = 1'b1;
                next_state = cpu_pkg::S_CHK_MORE_BYTES;
                next_byte_count = current_byte_count + 2'd1;
                case (current_byte_count)
                    2'd0: control_word.load_ir = 1'b1;     // Opcode
                    2'd1: control_word.load_temp_1 = 1'b1; // Low operand
                    2'd2: control_word.load_temp_2 = 1'b1; // High operand
                    default: begin
                        control_word = '0; // Overrun, stop the CPU
                        next_state = cpu_pkg::S_HALT;
                    end
                endcase
            end
            cpu_pkg::S_CHK_MORE_BYTES: begin
                if (!opcode_known) begin
                    next_state = cpu_pkg::S_HALT;
                end else if (current_byte_count == num_operand_bytes + 2'd1) begin
                    next_state = cpu_pkg::S_EXECUTE; // Opcode plus all operands in
                    next_byte_count = 2'd0;
                end else begin
                    next_state = cpu_pkg::S_LATCH_ADDR;
                end
            end
            cpu_pkg::S_EXECUTE: begin
                control_word = microcode_rom[opcode][current_microstep];
                check_jump = control_word.check_zero || control_word.check_carry ||
                             control_word.check_negative;
                jump_satisfied = (control_word.check_zero && flags[cpu_pkg::FLAG_Z]) ||
                                 (control_word.check_carry && flags[cpu_pkg::FLAG_C]) ||
                                 (control_word.check_negative && flags[cpu_pkg::FLAG_N]);
                if (control_word.halt) begin
                    next_state = cpu_pkg::S_HALT;
                    next_microstep = cpu_pkg::MS0;
                end else if (check_jump && !jump_satisfied) begin
                    control_word.load_pc = 1'b0; // Branch not taken
                    next_state = cpu_pkg::S_LATCH_ADDR;
                    next_microstep = cpu_pkg::MS0;
                end else if (control_word.last_step) begin
                    next_state = cpu_pkg::S_LATCH_ADDR;
                    next_microstep = cpu_pkg::MS0;
                end else begin
                    next_microstep = cpu_pkg::microstep_t'(current_microstep + 3'd1);
                end
            end
            cpu_pkg::S_HALT: next_state = cpu_pkg::S_HALT; // Only reset leaves
            default: next_state = cpu_pkg::S_HALT;
        endcase
    end

    assign halted = (current_state == cpu_pkg::S_HALT);

    // ================================================
    // Microcode ROM
    always_comb begin
        for (int op = 0; op < 256; op++) begin
            for (int s = 0; s < `MICROSTEPS; s++) begin
                microcode_rom[op][s] = '0; // Unused slots do nothing
            end
        end
        microcode_rom[cpu_pkg::NOP][cpu_pkg::MS0] = '{last_step: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::HLT][cpu_pkg::MS0] = '{halt: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::OUT][cpu_pkg::MS0] =
            '{out_strobe: 1'b1, last_step: 1'b1, default: 1'b0};

        // Absolute load, address from temp_2:temp_1
        microcode_rom[cpu_pkg::LDA][cpu_pkg::MS0] = '{oe_temp_1: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::LDA][cpu_pkg::MS1] =
            '{oe_temp_1: 1'b1, load_mar_addr_low: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::LDA][cpu_pkg::MS2] = '{oe_temp_2: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::LDA][cpu_pkg::MS3] =
            '{oe_temp_2: 1'b1, load_mar_addr_high: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::LDA][cpu_pkg::MS4] = '{oe_ram: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::LDA][cpu_pkg::MS5] = '{oe_ram: 1'b1, load_a: 1'b1,
            load_flags: 1'b1, load_sets_zn: 1'b1, last_step: 1'b1, default: 1'b0};

        // Immediates ride on temp_1
        microcode_rom[cpu_pkg::LDI_A][cpu_pkg::MS0] = '{oe_temp_1: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::LDI_A][cpu_pkg::MS1] = '{oe_temp_1: 1'b1, load_a: 1'b1,
            load_flags: 1'b1, load_sets_zn: 1'b1, last_step: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::ADDI][cpu_pkg::MS0] = '{oe_temp_1: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::ADDI][cpu_pkg::MS1] = '{oe_temp_1: 1'b1, alu_add: 1'b1,
            load_a: 1'b1, load_flags: 1'b1, last_step: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::SUBI][cpu_pkg::MS0] = '{oe_temp_1: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::SUBI][cpu_pkg::MS1] = '{oe_temp_1: 1'b1, alu_sub: 1'b1,
            load_a: 1'b1, load_flags: 1'b1, last_step: 1'b1, default: 1'b0};

        // Jumps, condition tested on MS0
        microcode_rom[cpu_pkg::JMP][cpu_pkg::MS1] =
            '{load_pc: 1'b1, last_step: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::JZ][cpu_pkg::MS0] = '{check_zero: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::JZ][cpu_pkg::MS1] =
            '{check_zero: 1'b1, load_pc: 1'b1, last_step: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::JC][cpu_pkg::MS0] = '{check_carry: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::JC][cpu_pkg::MS1] =
            '{check_carry: 1'b1, load_pc: 1'b1, last_step: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::JN][cpu_pkg::MS0] = '{check_negative: 1'b1, default: 1'b0};
        microcode_rom[cpu_pkg::JN][cpu_pkg::MS1] =
            '{check_negative: 1'b1, load_pc: 1'b1, last_step: 1'b1, default: 1'b0};
    end

    // Halt is sticky and silent until reset, IR and flags frozen
    a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
        halted |=> (halted && control_word == '0 && $stable(flags) && $stable(opcode)));

endmodule

// ==== hw/datapath.sv ====
`include "cpu_config.svh"

module datapath (
    input  logic                   clk,
    input  logic                   reset,
    input  cpu_pkg::control_word_t control_word,
    input  cpu_pkg::data_t         mem_data,
    output cpu_pkg::addr_t         mem_addr,
    output cpu_pkg::opcode_t       opcode,
    output cpu_pkg::flags_t        flags,
    output cpu_pkg::data_t         acc,
    output logic                   out_valid,
    output cpu_pkg::data_t         out_data
);

    // ================================================
    // Registers
    cpu_pkg::data_t   a;      // Accumulator
    cpu_pkg::opcode_t ir;     // Instruction register
    cpu_pkg::data_t   temp_1; // Low operand
    cpu_pkg::data_t   temp_2; // High operand
    cpu_pkg::addr_t   pc;
    cpu_pkg::addr_t   mar;
    cpu_pkg::flags_t  flags_q;

    cpu_pkg::data_t bus;        // Internal data bus
    logic [8:0]     sum;        // Add with carry-out
    logic [8:0]     diff;       // Sub with borrow-out
    cpu_pkg::data_t alu_result;

    // Bus source select, RAM has priority
    always_comb begin
        if (control_word.oe_ram) begin
            bus = mem_data;
        end else if (control_word.oe_temp_1) begin
            bus = temp_1;
        end else if (control_word.oe_temp_2) begin
            bus = temp_2;
        end else begin
            bus = '0;
        end
    end

    // ================================================
    // ALU
    assign sum = {1'b0, a} + {1'b0, bus};
    assign diff = {1'b0, a} - {1'b0, bus};

    always_comb begin
        if (control_word.alu_add) begin
            alu_result = sum[7:0];
        end else if (control_word.alu_sub) begin
            alu_result = diff[7:0];
        end else begin
            alu_result = bus; // Plain load
        end
    end

    // ================================================
    // Sequential state
    always_ff @(posedge clk) begin
        if (reset) begin
            a <= '0;
            ir <= cpu_pkg::NOP;
            pc <= `RESET_VECTOR;
            flags_q <= '0;
            out_valid <= 1'b0;
        end else begin
            if (control_word.load_origin) begin
                pc <= `RESET_VECTOR;
            end else if (control_word.load_pc) begin
                pc <= {temp_2, temp_1}; // Little-endian target
            end else if (control_word.pc_enable) begin
                pc <= pc + 16'd1;
            end
            if (control_word.load_ir) begin
                ir <= cpu_pkg::opcode_t'(bus);
            end
            if (control_word.load_a) begin
                a <= alu_result;
            end
            if (control_word.load_flags) begin
                flags_q[cpu_pkg::FLAG_Z] <= (alu_result == 8'h00);
                flags_q[cpu_pkg::FLAG_N] <= alu_result[7];
                if (!control_word.load_sets_zn && control_word.alu_add) begin
                    flags_q[cpu_pkg::FLAG_C] <= sum[8];   // Carry-out
                end else if (!control_word.load_sets_zn && control_word.alu_sub) begin
                    flags_q[cpu_pkg::FLAG_C] <= ~diff[8]; // No borrow
                end
            end
            out_valid <= control_word.out_strobe; // One-cycle pulse
        end
    end

    // Operands, address register and OUT payload
    always_ff @(posedge clk) begin
        if (control_word.load_temp_1) temp_1 <= bus;
        if (control_word.load_temp_2) temp_2 <= bus;
        if (control_word.load_mar_pc) begin
            mar <= pc;
        end else begin
            if (control_word.load_mar_addr_low) mar[7:0] <= bus;
            if (control_word.load_mar_addr_high) mar[15:8] <= bus;
        end
        if (control_word.out_strobe) out_data <= a;
    end

    assign mem_addr = mar;
    assign opcode = ir;
    assign flags = flags_q;
    assign acc = a;

    // Fetch and execute never share a bus cycle
    a_ir_a_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(control_word.load_ir && control_word.load_a));

endmodule

// ==== hw/ram.sv ====
`include "cpu_config.svh"

module ram (
    input  logic           clk,
    input  cpu_pkg::addr_t addr,
    output cpu_pkg::data_t rdata,
    input  logic           we,
    input  cpu_pkg::addr_t waddr,
    input  cpu_pkg::data_t wdata
);

    localparam int DEPTH = 2 ** `RAM_ADDR_BITS;

    cpu_pkg::data_t mem [DEPTH]; // Byte array

    // ================================================
    // Read port, combinational for the datapath
    assign rdata = mem[addr[`RAM_ADDR_BITS-1:0]]; // High bits dropped

    // Program port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[`RAM_ADDR_BITS-1:0]] <= wdata;
        end
    end

endmodule

// ==== hw/cpu_top.sv ====
module cpu_top (
    input  logic           clk,
    input  logic           reset,
    input  logic           prog_we,
    input  cpu_pkg::addr_t prog_addr,
    input  cpu_pkg::data_t prog_data,
    output logic           out_valid,
    output cpu_pkg::data_t out_data,
    output logic           halted,
    output cpu_pkg::data_t acc,
    output cpu_pkg::flags_t flags
);

    // ================================================
    // Internal nets
    cpu_pkg::control_word_t control_word; // Sequencer to datapath
    cpu_pkg::opcode_t       opcode;       // IR back to sequencer
    cpu_pkg::addr_t         mem_addr;
    cpu_pkg::data_t         mem_data;

    control_unit u_control_unit (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .flags        (flags),
        .control_word (control_word),
        .halted       (halted)
    );

    datapath u_datapath (
        .clk          (clk),
        .reset        (reset),
        .control_word (control_word),
        .mem_data     (mem_data),
        .mem_addr     (mem_addr),
        .opcode       (opcode),
        .flags        (flags),
        .acc          (acc),
        .out_valid    (out_valid),
        .out_data     (out_data)
    );

    ram u_ram (
        .clk   (clk),
        .addr  (mem_addr),
        .rdata (mem_data),
        .we    (prog_we),   // Loader only
        .waddr (prog_addr),
        .wdata (prog_data)
    );

endmodule

// ==== sim/tb_cpu.sv ====
module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS = 9;
    localparam int MAX_BYTES = 24; // Program image size
    localparam int MAX_OUTS = 4;
    localparam int CYCLE_LIMIT = NUM_TESTS * MAX_BYTES * 4 * 8 + 500; // Plus reset and halt slack

    typedef logic [8*MAX_BYTES-1:0] image_t; // Byte 0 sits highest in the used slice

    logic            clk;
    logic            reset;
    logic            prog_we;
    cpu_pkg::addr_t  prog_addr;
    cpu_pkg::data_t  prog_data;
    logic            out_valid;
    cpu_pkg::data_t  out_data;
    logic            halted;
    cpu_pkg::data_t  acc;
    cpu_pkg::flags_t flags;

    // ================================================
    // Stimulus and expected values
    string           test_name [NUM_TESTS];
    image_t          prog_image [NUM_TESTS];
    int              prog_len [NUM_TESTS];
    cpu_pkg::data_t  exp_out [NUM_TESTS][MAX_OUTS];
    int              exp_count [NUM_TESTS];
    cpu_pkg::data_t  exp_acc [NUM_TESTS];
    cpu_pkg::flags_t exp_flags [NUM_TESTS];

    int error_count = 0;
    int cycle_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    cpu_top DUT (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halted    (halted),
        .acc       (acc),
        .flags     (flags)
    );

    always #20 clk = ~clk; // 40 ns period

    // Watchdog over the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the CPU never halted", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
            error_count++;
        end
    endtask

    // Flags as {N, C, Z}
    function automatic cpu_pkg::flags_t zn_flags(input cpu_pkg::data_t value, input logic carry);
        return {value[7], carry, value == 8'h00};
    endfunction

    task automatic set_test(input int t, input string name, input int len, input image_t image);
        test_name[t] = name;
        prog_len[t] = len;
        prog_image[t] = image;
    endtask

    task automatic set_expect(input int t, input int count, input cpu_pkg::data_t o0,
                              input cpu_pkg::data_t o1, input cpu_pkg::data_t o2,
                              input cpu_pkg::data_t a, input cpu_pkg::flags_t f);
        exp_count[t] = count;
        exp_out[t][0] = o0;
        exp_out[t][1] = o1;
        exp_out[t][2] = o2;
        exp_out[t][3] = 8'h00; // Spare slot
        exp_acc[t] = a;
        exp_flags[t] = f;
    endtask

    // ================================================
    // Program table
    task automatic build_table();
        cpu_pkg::data_t imm;
        cpu_pkg::data_t rd;
        cpu_pkg::data_t a;
        cpu_pkg::data_t b;
        cpu_pkg::data_t c;
        cpu_pkg::data_t s1;
        cpu_pkg::data_t s2;
        imm = cpu_pkg::data_t'($urandom());
        rd = cpu_pkg::data_t'($urandom());
        a = cpu_pkg::data_t'($urandom());
        b = cpu_pkg::data_t'($urandom());
        c = cpu_pkg::data_t'($urandom());
        set_test(0, "ldi_out", 4, image_t'({8'h0C, imm, 8'h20, 8'h01}));
        set_expect(0, 1, imm, 8'h00, 8'h00, imm, zn_flags(imm, 1'b0)); // C untouched
        // Data at 0x14, fetched through 0x7314
        set_test(1, "lda_high_bits", 21,
            image_t'({8'h0A, 8'h14, 8'h73, 8'h20, 8'h01, {15{8'h00}}, rd}));
        set_expect(1, 1, rd, 8'h00, 8'h00, rd, zn_flags(rd, 1'b0));
        s1 = a + b; // 8-bit wrap
        s2 = s1 - c;
        set_test(2, "addi_subi", 9,
            image_t'({8'h0C, a, 8'h10, b, 8'h20, 8'h11, c, 8'h20, 8'h01}));
        set_expect(2, 2, s1, s2, 8'h00, s2, zn_flags(s2, s1 >= c)); // No borrow
        a = 8'h80 | cpu_pkg::data_t'($urandom()); // Both top bits set
        b = 8'h80 | cpu_pkg::data_t'($urandom());
        s1 = a + b;
        set_test(3, "addi_carry", 6, image_t'({8'h0C, a, 8'h10, b, 8'h20, 8'h01}));
        set_expect(3, 1, s1, 8'h00, 8'h00, s1, zn_flags(s1, (int'(a) + int'(b)) > 255));
        // Taken branch skips the OUT at 5, untaken one emits the OUT at 11
        set_test(4, "jz_both", 13, image_t'({8'h0C, 8'h00, 8'h31, 8'h06, 8'h00, 8'h20,
            8'h0C, 8'h05, 8'h31, 8'h0C, 8'h00, 8'h20, 8'h01}));
        set_expect(4, 1, 8'h05, 8'h00, 8'h00, 8'h05, zn_flags(8'h05, 1'b0));
        // FF+1 sets C, then 0-1 borrows and clears it
        set_test(5, "jc_both", 15, image_t'({8'h0C, 8'hFF, 8'h10, 8'h01, 8'h32, 8'h08,
            8'h00, 8'h20, 8'h11, 8'h01, 8'h32, 8'h0E, 8'h00, 8'h20, 8'h01}));
        set_expect(5, 1, 8'hFF, 8'h00, 8'h00, 8'hFF, zn_flags(8'hFF, 1'b0));
        set_test(6, "jn_both", 13, image_t'({8'h0C, 8'h80, 8'h33, 8'h06, 8'h00, 8'h20,
            8'h0C, 8'h01, 8'h33, 8'h0C, 8'h00, 8'h20, 8'h01}));
        set_expect(6, 1, 8'h01, 8'h00, 8'h00, 8'h01, zn_flags(8'h01, 1'b0));
        // Countdown from 3, last SUBI 1-1 leaves C set
        set_test(7, "countdown", 12, image_t'({8'h0C, 8'h03, 8'h11, 8'h01, 8'h20,
            8'h31, 8'h0B, 8'h00, 8'h30, 8'h02, 8'h00, 8'h01}));
        set_expect(7, 3, 8'h02, 8'h01, 8'h00, 8'h00, zn_flags(8'h00, 1'b1));
        set_test(8, "unknown_op", 6, image_t'({8'h0C, 8'h42, 8'h20, 8'hFF, 8'h20, 8'h01}));
        set_expect(8, 1, 8'h42, 8'h00, 8'h00, 8'h42, zn_flags(8'h42, 1'b0));
    endtask

    // ================================================
    // One table entry: load under reset, run to halt, check
    task automatic run_test(input int t);
        cpu_pkg::data_t got [$];
        int errors_before;
        errors_before = error_count;
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < prog_len[t]; i++) begin
            prog_we = 1'b1;
            prog_addr = cpu_pkg::addr_t'(i);
            prog_data = prog_image[t][8*(prog_len[t]-1-i) +: 8]; // Byte i of the image
            @(negedge clk);
        end
        prog_we = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        while (!halted) begin
            @(negedge clk);
            if (out_valid) begin
                got.push_back(out_data);
            end
        end
        check_value("strobe count", got.size(), exp_count[t]);
        for (int i = 0; i < exp_count[t] && i < got.size(); i++) begin
            check_value($sformatf("strobe %0d", i), got[i], exp_out[t][i]);
        end
        check_value("final acc", acc, exp_acc[t]);
        check_value("final flags", flags, exp_flags[t]);
        repeat (20) begin // Halt must stay quiet
            @(negedge clk);
            check_value("out_valid after halt", out_valid, 1'b0);
            check_value("halted after halt", halted, 1'b1);
        end
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %0d %s: passed", t, test_name[t]);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", t, test_name[t],
                     error_count - errors_before);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        void'($urandom(32'h181a_471c)); // Seeds the generator once
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/control_unit.sv
hw/datapath.sv
hw/ram.sv
hw/cpu_top.sv
sim/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_cpu -f project.f -o tb_cpu_sim \
    && ./obj_dir/tb_cpu_sim | tee /dev/stderr | grep -qF '** PASS **' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
